// ==== hw/muldiv_pkg.sv ====
////////////////////////////////////////
// muldiv package
// widths, divider stage mask, latencies, operation codes
// and the structs shared by the multiply and divide unit
////////////////////////////////////////
`default_nettype none

package muldiv_pkg;

	// data width of the core
	localparam int XLEN = 32;

	// a one at bit XLEN-1-i puts a register after divider step i
	// every fourth step is registered, the last step included
	localparam logic [XLEN-1:0] DIV_STAGE_MASK = 32'h1111_1111;

	// register stages inside the divider array
	localparam int DIV_ARRAY_LAT = $countones(DIV_STAGE_MASK);

	// sign input register, the array, then the sign output register
	localparam int MD_LATENCY = 1 + DIV_ARRAY_LAT + 1;

	// register stages inside the multiplier before its padding
	localparam int MUL_STAGES = 3;

	localparam int TAG_W = 4;

	// funct3 order of the M extension, so bit 2 splits mul from div
	typedef enum logic [2:0] {
		MD_MUL    = 3'd0,
		MD_MULH   = 3'd1,
		MD_MULHSU = 3'd2,
		MD_MULHU  = 3'd3,
		MD_DIV    = 3'd4,
		MD_DIVU   = 3'd5,
		MD_REM    = 3'd6,
		MD_REMU   = 3'd7
	} md_op_t;

	typedef struct packed {
		md_op_t            op;
		logic [XLEN-1:0]   rs1;
		logic [XLEN-1:0]   rs2;
		logic [TAG_W-1:0]  tag;
	} md_req_t;

	typedef struct packed {
		logic [XLEN-1:0]   result;
		logic [TAG_W-1:0]  tag;
	} md_rsp_t;

	// sidecar of the divide path
	// on entry neg_quo and neg_rem only say the op is signed
	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		logic              want_rem;
		logic              neg_quo;
		logic              neg_rem;
		logic              sel;
	} div_side_t;

	// sidecar of the multiply path
	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		logic              hi;
		logic              sel;
	} mul_side_t;

endpackage

`default_nettype wire

// ==== hw/delay_line.sv ====
////////////////////////////////////////
// delay line
// fixed chain of registers for any payload type
////////////////////////////////////////
`default_nettype none

module delay_line #(
	parameter int DEPTH = 1,
	parameter type T = logic
) (
	input  wire logic clk,
	input  wire logic rst,
	input  T          i_data,
	output T          o_data
);

	// one entry per cycle of delay, entry 0 is the newest
	T pipe [DEPTH];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int k = 0; k < DEPTH; k++) begin
				pipe[k] <= '0;
			end
		end else begin
			pipe[0] <= i_data;
			// shift every older entry one step along
			for (int k = 1; k < DEPTH; k++) begin
				pipe[k] <= pipe[k-1];
			end
		end
	end

	assign o_data = pipe[DEPTH-1];

endmodule

`default_nettype wire

// ==== hw/div_array.sv ====
////////////////////////////////////////
// unsigned restoring divider array
// XLEN conditional subtract steps, each step either
// registered or combinational as the stage mask says
////////////////////////////////////////
`default_nettype none

module div_array #(
	parameter logic [muldiv_pkg::XLEN-1:0] STAGE_MASK = muldiv_pkg::DIV_STAGE_MASK
) (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  wire logic                        i_valid,
	input  wire logic [muldiv_pkg::XLEN-1:0] i_dividend,
	input  wire logic [muldiv_pkg::XLEN-1:0] i_divisor,
	output logic                             o_valid,
	output logic [muldiv_pkg::XLEN-1:0]      o_quotient,
	output logic [muldiv_pkg::XLEN-1:0]      o_remainder
);

	localparam int W = muldiv_pkg::XLEN;

	// everything one step hands to the next
	// num holds the dividend bits not yet consumed, msb first
	typedef struct packed {
		logic         vld;
		logic [W-1:0] rem;
		logic [W-1:0] num;
		logic [W-1:0] den;
		logic [W-1:0] quo;
	} stage_t;

	// st[i] enters step i, st[W] leaves the array
	stage_t st [W+1];

	assign st[0] = '{vld: i_valid, rem: '0, num: i_dividend, den: i_divisor, quo: '0};

	for (genvar i = 0; i < W; i++) begin : g_step
		logic [W:0] trial;
		logic [W:0] diff;
		logic       fits;
		stage_t     nxt;

		// bring the next dividend bit into the partial remainder
		assign trial = {st[i].rem, st[i].num[W-1]};
		assign diff  = trial - {1'b0, st[i].den};
		// a zero divisor always fits, which gives the all ones quotient
		assign fits  = (trial >= {1'b0, st[i].den});

		always_comb begin
			nxt     = st[i];
			// after a subtraction the remainder is below the divisor so W bits hold it
			nxt.rem = fits ? diff[W-1:0] : trial[W-1:0];
			nxt.num = {st[i].num[W-2:0], 1'b0};
			// quotient bits arrive msb first
			nxt.quo = {st[i].quo[W-2:0], fits};
		end

		if (STAGE_MASK[W-1-i]) begin : g_reg
			// valid travels in the same register as the data
			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					st[i+1] <= '0;
				end else begin
					st[i+1] <= nxt;
				end
			end
		end else begin : g_wire
			assign st[i+1] = nxt;
		end
	end

	assign o_valid     = st[W].vld;
	assign o_quotient  = st[W].quo;
	assign o_remainder = st[W].rem;

endmodule

`default_nettype wire

// ==== hw/div_sign.sv ====
////////////////////////////////////////
// signed divide and remainder wrapper
// magnitudes in, sign fix out, division by zero
// falls out of the unsigned array
////////////////////////////////////////
`default_nettype none

module div_sign (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  wire logic                        i_valid,
	input  wire logic [muldiv_pkg::XLEN-1:0] i_rs1,
	input  wire logic [muldiv_pkg::XLEN-1:0] i_rs2,
	input  muldiv_pkg::div_side_t            i_side,
	output logic                             o_valid,
	output logic [muldiv_pkg::XLEN-1:0]      o_result,
	output muldiv_pkg::div_side_t            o_side
);

	localparam int W = muldiv_pkg::XLEN;

	logic                  a_neg;
	logic                  b_neg;
	logic                  in_valid;
	logic [W-1:0]          a_mag;
	logic [W-1:0]          b_mag;
	muldiv_pkg::div_side_t in_side;
	logic                  arr_valid;
	logic [W-1:0]          arr_quo;
	logic [W-1:0]          arr_rem;
	muldiv_pkg::div_side_t arr_side;

	// on entry the neg flags only mark a signed op
	assign a_neg = i_side.neg_rem & i_rs1[W-1];
	assign b_neg = i_side.neg_quo & i_rs2[W-1];

	////////////////////////////////////////
	// input register
	////////////////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			in_valid <= 1'b0;
			a_mag    <= '0;
			b_mag    <= '0;
			in_side  <= '0;
		end else begin
			in_valid <= i_valid;
			// the most negative value stays 2^(W-1), which is its unsigned magnitude
			a_mag    <= a_neg ? -i_rs1 : i_rs1;
			b_mag    <= b_neg ? -i_rs2 : i_rs2;
			in_side  <= i_side;
			// a zero divisor keeps the all ones quotient unsigned
			in_side.neg_quo <= i_side.neg_quo & (i_rs1[W-1] ^ i_rs2[W-1]) & (|i_rs2);
			// remainder takes the sign of the dividend
			in_side.neg_rem <= a_neg;
		end
	end

	div_array u_array (
		.clk         (clk),
		.rst         (rst),
		.i_valid     (in_valid),
		.i_dividend  (a_mag),
		.i_divisor   (b_mag),
		.o_valid     (arr_valid),
		.o_quotient  (arr_quo),
		.o_remainder (arr_rem)
	);

	// flags ride beside the array for the same number of cycles
	delay_line #(
		.DEPTH (muldiv_pkg::DIV_ARRAY_LAT),
		.T     (muldiv_pkg::div_side_t)
	) u_side_dly (
		.clk    (clk),
		.rst    (rst),
		.i_data (in_side),
		.o_data (arr_side)
	);

	////////////////////////////////////////
	// output register
	////////////////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_valid  <= 1'b0;
			o_result <= '0;
			o_side   <= '0;
		end else begin
			o_valid <= arr_valid;
			o_side  <= arr_side;
			if (arr_side.want_rem) begin
				o_result <= arr_side.neg_rem ? -arr_rem : arr_rem;
			end else begin
				o_result <= arr_side.neg_quo ? -arr_quo : arr_quo;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/mul_pipe.sv ====
////////////////////////////////////////
// multiply path
// 33 by 33 signed product in three stages for DSP
// inference, then padded out to the unit latency
////////////////////////////////////////
`default_nettype none

module mul_pipe (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  wire logic                        i_valid,
	input  wire logic [muldiv_pkg::XLEN-1:0] i_rs1,
	input  wire logic [muldiv_pkg::XLEN-1:0] i_rs2,
	input  wire logic                        i_rs1_signed,
	input  wire logic                        i_rs2_signed,
	input  muldiv_pkg::mul_side_t            i_side,
	output logic                             o_valid,
	output logic [muldiv_pkg::XLEN-1:0]      o_result,
	output muldiv_pkg::mul_side_t            o_side
);

	localparam int W   = muldiv_pkg::XLEN;
	localparam int PAD = muldiv_pkg::MD_LATENCY - muldiv_pkg::MUL_STAGES;

	// valid and result padded together
	typedef struct packed {
		logic         valid;
		logic [W-1:0] result;
	} mul_out_t;

	logic                  v1, v2;
	logic signed [W:0]     a_ext, b_ext;
	logic signed [2*W+1:0] prod;
	muldiv_pkg::mul_side_t side1, side2, side3;
	mul_out_t              out3, out_d;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			v1    <= 1'b0;
			v2    <= 1'b0;
			a_ext <= '0;
			b_ext <= '0;
			prod  <= '0;
			out3  <= '0;
			side1 <= '0;
			side2 <= '0;
			side3 <= '0;
		end else begin
			// stage one, unsigned operands get a zero top bit
			v1    <= i_valid;
			a_ext <= {i_rs1_signed & i_rs1[W-1], i_rs1};
			b_ext <= {i_rs2_signed & i_rs2[W-1], i_rs2};
			side1 <= i_side;
			// stage two, one signed product covers all four ops
			v2    <= v1;
			prod  <= a_ext * b_ext;
			side2 <= side1;
			// stage three, pick the half the op wants
			out3.valid  <= v2;
			out3.result <= side2.hi ? prod[2*W-1:W] : prod[W-1:0];
			side3 <= side2;
		end
	end

	delay_line #(
		.DEPTH (PAD),
		.T     (mul_out_t)
	) u_out_dly (
		.clk    (clk),
		.rst    (rst),
		.i_data (out3),
		.o_data (out_d)
	);

	delay_line #(
		.DEPTH (PAD),
		.T     (muldiv_pkg::mul_side_t)
	) u_side_dly (
		.clk    (clk),
		.rst    (rst),
		.i_data (side3),
		.o_data (o_side)
	);

	assign o_valid  = out_d.valid;
	assign o_result = out_d.result;

endmodule

`default_nettype wire

// ==== hw/muldiv_top.sv ====
////////////////////////////////////////
// RV32 M extension unit
// decodes the op, feeds the multiply or divide path
// and merges the in-order responses
////////////////////////////////////////
`default_nettype none

module muldiv_top (
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic          i_req_valid,
	input  muldiv_pkg::md_req_t i_req,
	output logic               o_rsp_valid,
	output muldiv_pkg::md_rsp_t o_rsp
);

	logic                             is_div;
	logic                             div_go;
	logic                             mul_go;
	logic                             rs1_signed;
	logic                             rs2_signed;
	muldiv_pkg::div_side_t            div_in_side;
	muldiv_pkg::mul_side_t            mul_in_side;
	logic                             div_valid;
	logic                             mul_valid;
	logic [muldiv_pkg::XLEN-1:0]      div_result;
	logic [muldiv_pkg::XLEN-1:0]      mul_result;
	muldiv_pkg::div_side_t            div_out_side;
	muldiv_pkg::mul_side_t            mul_out_side;

	////////////////////////////////////////
	// decode
	////////////////////////////////////////
	// funct3 bit 2 marks the divide ops
	assign is_div = i_req.op[2];
	assign div_go = i_req_valid & is_div;
	assign mul_go = i_req_valid & ~is_div;

	// low half of mul is the same for any signedness
	assign rs1_signed = (i_req.op == muldiv_pkg::MD_MULH) | (i_req.op == muldiv_pkg::MD_MULHSU);
	assign rs2_signed = (i_req.op == muldiv_pkg::MD_MULH);

	// bit 1 picks rem over div, bit 0 marks the unsigned forms
	assign div_in_side = '{tag: i_req.tag, want_rem: i_req.op[1], neg_quo: ~i_req.op[0],
		neg_rem: ~i_req.op[0], sel: div_go};
	assign mul_in_side = '{tag: i_req.tag, hi: (i_req.op != muldiv_pkg::MD_MUL), sel: mul_go};

	div_sign u_div (
		.clk      (clk),
		.rst      (rst),
		.i_valid  (div_go),
		.i_rs1    (i_req.rs1),
		.i_rs2    (i_req.rs2),
		.i_side   (div_in_side),
		.o_valid  (div_valid),
		.o_result (div_result),
		.o_side   (div_out_side)
	);

	mul_pipe u_mul (
		.clk          (clk),
		.rst          (rst),
		.i_valid      (mul_go),
		.i_rs1        (i_req.rs1),
		.i_rs2        (i_req.rs2),
		.i_rs1_signed (rs1_signed),
		.i_rs2_signed (rs2_signed),
		.i_side       (mul_in_side),
		.o_valid      (mul_valid),
		.o_result     (mul_result),
		.o_side       (mul_out_side)
	);

	////////////////////////////////////////
	// merge
	////////////////////////////////////////
	// equal latency on both paths means one valid at most per cycle
	assign o_rsp_valid = div_valid | mul_valid;

	always_comb begin
		o_rsp = '0;
		if (div_out_side.sel) begin
			o_rsp.result = div_result;
			o_rsp.tag    = div_out_side.tag;
		end else if (mul_out_side.sel) begin
			o_rsp.result = mul_result;
			o_rsp.tag    = mul_out_side.tag;
		end
	end

endmodule

`default_nettype wire

// ==== verif/muldiv_properties.sv ====
////////////////////////////////////////
// muldiv timing properties
// fixed latency, tag order and reset behavior
// of the unit, bound onto muldiv_top
////////////////////////////////////////
`default_nettype none

module muldiv_properties (
	input wire logic           clk,
	input wire logic           rst,
	input wire logic           i_req_valid,
	input muldiv_pkg::md_req_t i_req,
	input wire logic           o_rsp_valid,
	input muldiv_pkg::md_rsp_t o_rsp
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int LAT = muldiv_pkg::MD_LATENCY;

	// number of property failures seen so far
	int unsigned fail_count = 0;

	// a request comes back exactly LAT edges later under the same tag
	// a reset in between cancels the attempt, the request is lost with the pipeline
	a_req_to_rsp: assert property (@(posedge clk) disable iff (rst)
		i_req_valid |-> ##LAT (o_rsp_valid && o_rsp.tag == $past(i_req.tag, LAT)))
	else begin
		$error("request did not come back %0d cycles later with its tag", LAT);
		fail_count++;
	end

	// every response has a request LAT edges behind it
	a_rsp_has_req: assert property (@(posedge clk) disable iff (rst)
		o_rsp_valid |-> $past(i_req_valid, LAT))
	else begin
		$error("response strobe with no request %0d cycles earlier", LAT);
		fail_count++;
	end

	// the response strobe stays low while reset is held
	a_rst_quiet: assert property (@(posedge clk) rst |-> !o_rsp_valid)
	else begin
		$error("response strobe high during reset");
		fail_count++;
	end

	// and in the first cycle after reset is released
	a_rst_first: assert property (@(posedge clk) $fell(rst) |-> !o_rsp_valid)
	else begin
		$error("response strobe high in the first cycle after reset");
		fail_count++;
	end

	a_rsp_known: assert property (@(posedge clk) o_rsp_valid |-> !$isunknown(o_rsp))
	else begin
		$error("response holds unknown bits while its strobe is high");
		fail_count++;
	end

endmodule

bind muldiv_top muldiv_properties u_props (
	.clk         (clk),
	.rst         (rst),
	.i_req_valid (i_req_valid),
	.i_req       (i_req),
	.o_rsp_valid (o_rsp_valid),
	.o_rsp       (o_rsp)
);

`default_nettype wire

// ==== verif/tb_muldiv.sv ====
////////////////////////////////////////
// muldiv testbench
// directed and random M extension traffic checked
// against a reference model, with a reset mid burst
////////////////////////////////////////
`default_nettype none

module tb_muldiv;
	timeunit 1ns;
	timeprecision 1ps;

	// one outstanding request as the model sees it
	typedef struct {
		string               name;
		muldiv_pkg::md_rsp_t rsp;
	} exp_t;

	// requests per test, in the order the tests run
	localparam int N_REQ = 100 + 32 + 64 + 20 + 4 + 20 + 9;
	localparam int N_DRAIN = 7;
	// each drain waits out the full latency plus a few cycles of slack
	localparam int STIM_CYCLES = N_REQ + N_DRAIN * (muldiv_pkg::MD_LATENCY + 4) + 2 * 3 + 12;
	localparam int TIMEOUT_CYCLES = STIM_CYCLES + 40;

	localparam logic [31:0] EXTREMES [5] = '{32'h0000_0000, 32'h0000_0001,
		32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};

	logic                         clk;
	logic                         rst;
	logic                         i_req_valid;
	muldiv_pkg::md_req_t          i_req;
	logic                         o_rsp_valid;
	muldiv_pkg::md_rsp_t          o_rsp;

	exp_t                         exp_q [$];
	exp_t                         front;
	logic [muldiv_pkg::TAG_W-1:0] next_tag;
	logic [31:0]                  rng_state;
	int                           cycle_count;

	muldiv_top dut0 (
		.clk         (clk),
		.rst         (rst),
		.i_req_valid (i_req_valid),
		.i_req       (i_req),
		.o_rsp_valid (o_rsp_valid),
		.o_rsp       (o_rsp)
	);

	always #20 clk = ~clk;

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////
	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// RISC-V M rules on top of plain 64-bit arithmetic
	// longint division cannot overflow, so min by -1 needs no special case here
	function automatic logic [31:0] ref_result(input muldiv_pkg::md_op_t op,
		input logic [31:0] a, input logic [31:0] b);
		longint      sa;
		longint      sb;
		longint      ua;
		longint      ub;
		logic [63:0] wide;
		sa = $signed(a);
		sb = $signed(b);
		ua = a;
		ub = b;
		case (op)
			muldiv_pkg::MD_MUL:    wide = sa * sb;
			muldiv_pkg::MD_MULH:   wide = (sa * sb) >> 32;
			muldiv_pkg::MD_MULHSU: wide = (sa * ub) >> 32;
			muldiv_pkg::MD_MULHU:  wide = (ua * ub) >> 32;
			muldiv_pkg::MD_DIV:    wide = (b == 0) ? -64'sd1 : sa / sb;
			muldiv_pkg::MD_DIVU:   wide = (b == 0) ? 64'hffff_ffff : ua / ub;
			muldiv_pkg::MD_REM:    wide = (b == 0) ? ua : sa % sb;
			default:               wide = (b == 0) ? ua : ua % ub;
		endcase
		return wide[31:0];
	endfunction

	task automatic abort_run();
		$display("TB FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	// drive one request on the next edge and queue what should come back
	task automatic issue(input muldiv_pkg::md_op_t op, input logic [31:0] a,
		input logic [31:0] b, input string name);
		exp_t e;
		@(posedge clk);
		#2;
		i_req_valid = 1'b1;
		i_req = '{op: op, rs1: a, rs2: b, tag: next_tag};
		e.name = name;
		e.rsp = '{result: ref_result(op, a, b), tag: next_tag};
		exp_q.push_back(e);
		next_tag++;
	endtask

	task automatic drain();
		@(posedge clk);
		#2;
		i_req_valid = 1'b0;
		i_req = '0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		// let the last properties finish their attempts
		repeat (2) @(posedge clk);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#2;
		i_req_valid = 1'b0;
		i_req = '0;
		rst = 1'b1;
		// whatever was in flight is dropped with the pipeline
		exp_q.delete();
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;
	endtask

	////////////////////////////////////////
	// checking
	////////////////////////////////////////
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	// outputs are settled by the falling edge
	always @(negedge clk) begin
		if (dut0.u_props.fail_count != 0) begin
			$display("a bound property on latency, order or reset failed");
			abort_run();
		end else if (!rst && o_rsp_valid) begin
			if (exp_q.size() == 0) begin
				$display("response with tag %0h arrived with no request in flight", o_rsp.tag);
				abort_run();
			end else begin
				front = exp_q.pop_front();
				assert (o_rsp.result === front.rsp.result && o_rsp.tag === front.rsp.tag)
				else begin
					$display("Fail %s expected %08h tag %0h actual %08h tag %0h", front.name,
						front.rsp.result, front.rsp.tag, o_rsp.result, o_rsp.tag);
					abort_run();
				end
			end
		end
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////
	initial begin
		logic [31:0] a;
		logic [31:0] b;
		clk = 1'b0;
		rst = 1'b0;
		i_req_valid = 1'b0;
		i_req = '0;
		next_tag = '0;
		rng_state = 32'h3bbd_563c;
		cycle_count = 0;
		// a clean rising edge on rst so the async reset fires
		#1;
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;

		// every multiply op on every pair of extreme operands
		for (int op = 0; op < 4; op++) begin
			for (int i = 0; i < 5; i++) begin
				for (int j = 0; j < 5; j++) begin
					issue(muldiv_pkg::md_op_t'(op), EXTREMES[i], EXTREMES[j], "mul_directed");
				end
			end
		end
		drain();

		for (int op = 0; op < 4; op++) begin
			for (int k = 0; k < 8; k++) begin
				a = lcg_next();
				b = lcg_next();
				issue(muldiv_pkg::md_op_t'(op), a, b, "mul_random");
			end
		end
		drain();

		// shifting the divisor down gives quotients of every size
		for (int op = 4; op < 8; op++) begin
			for (int k = 0; k < 16; k++) begin
				a = lcg_next();
				b = lcg_next();
				b = b >> a[31:27];
				issue(muldiv_pkg::md_op_t'(op), a, b, "div_random");
			end
		end
		drain();

		// zero divisor with dividends of both signs
		for (int op = 4; op < 8; op++) begin
			for (int i = 0; i < 5; i++) begin
				issue(muldiv_pkg::md_op_t'(op), EXTREMES[i], 32'h0, "div_by_zero");
			end
		end
		drain();

		// most negative value over minus one
		for (int op = 4; op < 8; op++) begin
			issue(muldiv_pkg::md_op_t'(op), 32'h8000_0000, 32'hffff_ffff, "div_overflow");
		end
		drain();

		// one request every cycle with the op picked at random
		for (int k = 0; k < 20; k++) begin
			a = lcg_next();
			b = lcg_next();
			issue(muldiv_pkg::md_op_t'(a[30:28]), a, b >> b[31:28], "burst");
		end
		drain();

		// reset lands while this burst is still in the pipeline
		for (int k = 0; k < 8; k++) begin
			a = lcg_next();
			b = lcg_next();
			issue(muldiv_pkg::md_op_t'(a[30:28]), a, b, "reset_burst");
		end
		apply_reset();
		// a stray response here would find the queue empty
		repeat (12) @(posedge clk);
		a = lcg_next();
		b = lcg_next();
		issue(muldiv_pkg::MD_DIV, a, b >> 20, "after_reset");
		drain();

		if (exp_q.size() == 0 && dut0.u_props.fail_count == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("responses still outstanding at the end of the run");
			abort_run();
		end
	end

endmodule

`default_nettype wire

// ==== rv_muldiv.f ====
hw/muldiv_pkg.sv
hw/delay_line.sv
hw/div_array.sv
hw/div_sign.sv
hw/mul_pipe.sv
hw/muldiv_top.sv
verif/muldiv_properties.sv
verif/tb_muldiv.sv
